// ==== ddr3_rd_path.f ====
+incdir+verilog
verilog/ddr3_rd_pkg.sv
verilog/rd_path_ifs.sv
verilog/ddr3_rd_control.sv
verilog/ddr3_rd_fifo.sv
verilog/burst_unpacker.sv
verilog/ddr3_rd_path.sv
test/ddr3_app_model.sv
test/tb_ddr3_rd_path.sv

// ==== test/tb_ddr3_rd_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_defs.svh"

module tb_ddr3_rd_path import ddr3_rd_pkg::*; ();

	localparam int FILLS   = 12;
	localparam int MAX_CNT = 40;	// bursts per fill at most
	localparam int LIMIT   = FILLS * (MAX_CNT * 4 * 4 + MAX_CNT);	// cycles for the whole run
	localparam int unsigned ADDR_SPAN = (1 << `RD_ADDR_W) - 64;	// start low enough not to wrap

	logic        clk;
	logic        reset;
	logic        acq_enabled;
	burst_addr_t rd_start_addr;
	burst_cnt_t  rd_burst_cnt;
	logic        enable_reading;
	logic        reading_done;
	app_addr_t   rd_app_addr;
	logic        rd_app_en;
	logic        rd_app_rdy;
	logic        app_rd_data_valid;
	beat_t       app_rd_data;
	logic        out_stall;
	logic        out_valid;
	word_t       out_word;
	logic        out_last;

	integer      seed = 32'hdb04_c342;
	int          cycles = 0;
	int          error_count = 0;
	logic        in_fill;	// enable_reading is up for the current fill
	burst_addr_t fill_start;
	int          fill_cnt;
	int          fill_words;	// words the fill must deliver
	int          word_idx;	// words seen so far
	int          addr_seen;	// addresses accepted so far
	burst_addr_t exp_addr;	// next burst address expected on the app port

	ddr3_rd_path u_ddr3_rd_path (
		.clk               (clk),
		.reset             (reset),
		.acq_enabled       (acq_enabled),
		.rd_start_addr     (rd_start_addr),
		.rd_burst_cnt      (rd_burst_cnt),
		.enable_reading    (enable_reading),
		.reading_done      (reading_done),
		.rd_app_addr       (rd_app_addr),
		.rd_app_en         (rd_app_en),
		.rd_app_rdy        (rd_app_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.out_stall         (out_stall),
		.out_valid         (out_valid),
		.out_word          (out_word),
		.out_last          (out_last)
	);

	ddr3_app_model u_app_model (
		.clk               (clk),
		.reset             (reset),
		.rd_app_en         (rd_app_en),
		.rd_app_addr       (rd_app_addr),
		.rd_app_rdy        (rd_app_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		stop_run();
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("ERROR %s", what);
		stop_run();
	endtask

	// word idx of a fill, counted from the start burst, four words per burst
	function automatic word_t expected_word(input burst_addr_t start, input int idx);
		return word_t'(start) * 4 + idx;
	endfunction

	// random levels on the falling edge, about eight cycles per run
	task automatic toggle_controls();
		@(negedge clk);
		if ($unsigned($random(seed)) % 8 == 0)
			acq_enabled = !acq_enabled;
		if ($unsigned($random(seed)) % 8 == 0)
			out_stall = !out_stall;
	endtask

	task automatic check_quiet(input string when);
		assert (!rd_app_en) else report_problem({"rd_app_en high ", when});
		assert (!out_valid) else report_problem({"out_valid high ", when});
		assert (!out_last) else report_problem({"out_last high ", when});
		assert (!reading_done) else report_problem({"reading_done high ", when});
	endtask

	task automatic run_fill(input int index);
		burst_addr_t start;
		int          cnt;
		start = burst_addr_t'($unsigned($random(seed)) % ADDR_SPAN);
		cnt   = $unsigned($random(seed)) % (MAX_CNT + 1);
		if (index == 2)
			cnt = 0;	// one empty fill at least
		@(negedge clk);
		rd_start_addr  = start;
		rd_burst_cnt   = burst_cnt_t'(cnt);
		fill_start     = start;
		fill_cnt       = cnt;
		fill_words     = cnt * 4;
		word_idx       = 0;
		addr_seen      = 0;
		exp_addr       = start;
		enable_reading = 1'b1;
		in_fill        = 1'b1;
		while (!(reading_done && word_idx == fill_words))
			toggle_controls();
		assert (addr_seen == fill_cnt)
			else report_mismatch("address count", fill_cnt, addr_seen);
		enable_reading = 1'b0;
		in_fill        = 1'b0;
		repeat (4) toggle_controls();	// synchronizer and state settle
		@(negedge clk);
		check_quiet("after enable_reading drops");
	endtask

	// checks on the rising edge, before the DUT registers move
	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT)
			report_problem("timeout, the fills did not finish in time");
		if (!reset) begin
			assert (!(rd_app_en && acq_enabled))
				else report_problem("rd_app_en high while acq_enabled is high");
			assert (!rd_app_en || (in_fill && !reading_done))
				else report_problem("rd_app_en high outside an active fill");
			if (rd_app_en && rd_app_rdy) begin
				assert (addr_seen < fill_cnt)
					else report_problem("more addresses accepted than the burst count");
				assert (rd_app_addr == app_addr_t'({exp_addr, 3'b000}))
					else report_mismatch("app address", {exp_addr, 3'b000}, rd_app_addr);
				exp_addr++;
				addr_seen++;
			end
			assert (!(out_stall && out_valid))
				else report_problem("out_valid high while out_stall is high");
			assert (out_valid || !out_last) else report_problem("out_last without out_valid");
			if (out_valid) begin
				assert (word_idx < fill_words) else report_problem("word beyond the end of the fill");
				assert (out_word == expected_word(fill_start, word_idx))
					else report_mismatch("output word", expected_word(fill_start, word_idx), out_word);
				assert (out_last == (word_idx == fill_words - 1))
					else report_mismatch("out_last", word_idx == fill_words - 1, out_last);
				word_idx++;
			end
		end
	end

	initial begin
		reset          = 1'b1;
		acq_enabled    = 1'b0;
		rd_start_addr  = '0;
		rd_burst_cnt   = '0;
		enable_reading = 1'b0;
		out_stall      = 1'b0;
		in_fill        = 1'b0;
		fill_start     = '0;
		fill_cnt       = 0;
		fill_words     = 0;
		word_idx       = 0;
		addr_seen      = 0;
		exp_addr       = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_quiet("after reset");
		for (int f = 0; f < FILLS; f++)
			run_fill(f);
		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

`default_nettype wire

// ==== test/ddr3_app_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_defs.svh"

// memory controller app port, read side only
module ddr3_app_model import ddr3_rd_pkg::*; #(
	parameter int SEED = 32'hdb04_c342
) (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic       rd_app_en,
	input  wire app_addr_t  rd_app_addr,
	output logic            rd_app_rdy,
	output logic            app_rd_data_valid,
	output beat_t           app_rd_data
);

	integer      seed = SEED;
	burst_addr_t pend_addr [$];	// accepted bursts, oldest first
	int          pend_due [$];	// cycle each burst may return
	int          cycle = 0;
	int          last_due = 0;	// keeps returns in request order

	initial begin
		rd_app_rdy        = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data       = '0;
	end

	// take addresses where the DUT sees them, on the rising edge
	always @(posedge clk) begin
		int lat;
		int due;
		if (reset) begin
			pend_addr.delete();
			pend_due.delete();
			last_due = 0;
		end else if (rd_app_en && rd_app_rdy) begin
			lat = 1 + ($unsigned($random(seed)) % 5);	// 1 to 5 cycles
			due = cycle + lat;
			if (due <= last_due)
				due = last_due + 1;	// never overtake an older read
			pend_addr.push_back(burst_addr_t'(rd_app_addr >> 3));
			pend_due.push_back(due);
			last_due = due;
		end
		cycle = cycle + 1;
	end

	// ready and return data change on the falling edge
	always @(negedge clk) begin
		burst_addr_t a;
		if (reset) begin
			rd_app_rdy        = 1'b0;
			app_rd_data_valid = 1'b0;
			app_rd_data       = '0;
		end else begin
			// four reads outstanding at most, counting the one about to return
			rd_app_rdy = (pend_addr.size() < 4) && ($unsigned($random(seed)) % 4 != 0);
			app_rd_data_valid = 1'b0;
			if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
				a = pend_addr.pop_front();
				void'(pend_due.pop_front());
				app_rd_data_valid = 1'b1;
				for (int k = 0; k < 4; k++)
					app_rd_data[k*`WORD_W +: `WORD_W] = word_t'(a) * 4 + k;	// word k = a*4+k
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ddr3_rd_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_defs.svh"

module ddr3_rd_path import ddr3_rd_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	// fill request
	input  wire logic        acq_enabled,	// writes own the memory while high
	input  wire burst_addr_t rd_start_addr,
	input  wire burst_cnt_t  rd_burst_cnt,
	input  wire logic        enable_reading,
	output logic             reading_done,
	// memory controller app port, read side
	output app_addr_t        rd_app_addr,
	output logic             rd_app_en,
	input  wire logic        rd_app_rdy,
	input  wire logic        app_rd_data_valid,
	input  wire beat_t       app_rd_data,
	// word stream out
	input  wire logic        out_stall,
	output logic             out_valid,
	output word_t            out_word,
	output logic             out_last
);

	rd_fifo_wr_if wr_bus ();	// controller into FIFO
	rd_fifo_rd_if rd_bus ();	// FIFO into unpacker

	ddr3_rd_control u_ddr3_rd_control (
		.clk               (clk),
		.reset             (reset),
		.acq_enabled       (acq_enabled),
		.rd_start_addr     (rd_start_addr),
		.rd_burst_cnt      (rd_burst_cnt),
		.enable_reading    (enable_reading),
		.reading_done      (reading_done),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.rd_app_rdy        (rd_app_rdy),
		.rd_app_addr       (rd_app_addr),
		.rd_app_en         (rd_app_en),
		.fifo              (wr_bus.producer)
	);

	// depth must cover the almost-full margin plus reads in flight
	ddr3_rd_fifo #(
		.DEPTH (`RD_FIFO_DEPTH)
	) u_ddr3_rd_fifo (
		.clk   (clk),
		.reset (reset),
		.wr    (wr_bus.fifo),
		.rd    (rd_bus.fifo)
	);

	burst_unpacker u_burst_unpacker (
		.clk       (clk),
		.reset     (reset),
		.fifo      (rd_bus.consumer),
		.out_stall (out_stall),
		.out_valid (out_valid),
		.out_word  (out_word),
		.out_last  (out_last)
	);

endmodule

`default_nettype wire

// ==== verilog/burst_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_defs.svh"

module burst_unpacker import ddr3_rd_pkg::*; (
	input  wire logic clk,
	input  wire logic reset,
	rd_fifo_rd_if.consumer fifo,
	input  wire logic out_stall,	// downstream hold, no word leaves while high
	output logic      out_valid,
	output word_t     out_word,
	output logic      out_last	// last word of the fill
);

	localparam word_sel_t LAST_SEL = 2'd3;	// word 3 is the top of the beat

	beat_t     beat_q;	// beat being sent out
	logic      last_q;	// beat was marked last
	logic      loaded;	// beat_q holds words still to send
	word_sel_t sel;	// word currently on out_word
	logic      advance;	// a word leaves this cycle
	logic      pop;

	assign advance = loaded && !out_stall;

	// refill when idle, or in the same cycle word 3 leaves so beats run back to back
	assign pop = !fifo.empty && (!loaded || (advance && sel == LAST_SEL));
	assign fifo.rd_en = pop;

	always_ff @(posedge clk) begin
		if (reset) begin
			loaded <= 1'b0;
			sel    <= '0;
		end else if (pop) begin
			loaded <= 1'b1;
			sel    <= '0;	// start from the least significant word
		end else if (advance) begin
			if (sel == LAST_SEL)
				loaded <= 1'b0;	// beat used up, FIFO was empty
			else
				sel <= sel + 1'b1;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (pop) begin
			beat_q <= fifo.rd_data;
			last_q <= fifo.rd_last;
		end
	end

	assign out_valid = advance;
	assign out_word  = beat_q[sel*`WORD_W +: `WORD_W];	// lsw first
	assign out_last  = advance && last_q && (sel == LAST_SEL);

endmodule

`default_nettype wire

// ==== verilog/ddr3_rd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_defs.svh"

module ddr3_rd_fifo import ddr3_rd_pkg::*; #(
	parameter int DEPTH = `RD_FIFO_DEPTH	// entries, need not be a power of two
) (
	input  wire logic clk,
	input  wire logic reset,
	rd_fifo_wr_if.fifo wr,
	rd_fifo_rd_if.fifo rd
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);	// count goes up to DEPTH

	beat_t             mem [DEPTH];	// beat storage
	logic              last_mem [DEPTH];	// fill end flag per entry
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic [CNT_W-1:0]  count_next;
	logic              afull_q;

	// circular pointer step
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// storage, write side only
	always_ff @(posedge clk) begin
		if (wr.wr_en) begin
			mem[wr_ptr]      <= wr.wr_data;
			last_mem[wr_ptr] <= wr.wr_last;
		end
	end

	// occupancy after this cycle's push and pop
	always_comb begin
		count_next = count;
		case ({wr.wr_en, rd.rd_en})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;	// both or none
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			afull_q <= 1'b0;
		end else begin
			if (wr.wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd.rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			count   <= count_next;
			afull_q <= (DEPTH - count_next) <= `RD_FIFO_AFULL_MARGIN;	// free space low
		end
	end

	assign wr.almost_full = afull_q;

	// head entry shows without a pop
	assign rd.empty   = (count == '0);
	assign rd.rd_data = mem[rd_ptr];
	assign rd.rd_last = last_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== verilog/ddr3_rd_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_defs.svh"

module ddr3_rd_control import ddr3_rd_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        acq_enabled,	// acquisition writing, no reads allowed
	input  wire burst_addr_t rd_start_addr,	// first burst of the fill
	input  wire burst_cnt_t  rd_burst_cnt,	// bursts to read
	input  wire logic        enable_reading,	// level, starts the fill
	output logic             reading_done,
	input  wire logic        app_rd_data_valid,
	input  wire beat_t       app_rd_data,
	input  wire logic        rd_app_rdy,	// memory controller takes the address
	output app_addr_t        rd_app_addr,
	output logic             rd_app_en,
	rd_fifo_wr_if.producer   fifo
);

	logic        en_sync1, en_sync2, en_sync3;	// enable_reading synchronizer
	logic        start_pulse;	// one cycle, loads address and counters
	logic        addr_accept;
	burst_addr_t addr_gen;
	burst_cnt_t  addr_cntr;	// addresses still to issue
	burst_cnt_t  burst_cntr;	// beats still to receive
	logic        addr_cntr_zero;
	logic        burst_cntr_zero;
	logic        burst_cntr_one;
	rd_state_t   state, state_next;

	// three stage synchronizer plus rising edge pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			en_sync1    <= 1'b0;
			en_sync2    <= 1'b0;
			en_sync3    <= 1'b0;
			start_pulse <= 1'b0;
		end else begin
			en_sync1    <= enable_reading;
			en_sync2    <= en_sync1;
			en_sync3    <= en_sync2;
			start_pulse <= en_sync2 & ~en_sync3;	// fires as sync3 goes high
		end
	end

	assign addr_accept = rd_app_en & rd_app_rdy;	// address handed over this cycle

	// address generator
	always_ff @(posedge clk) begin
		if (reset)
			addr_gen <= '0;
		else if (start_pulse)
			addr_gen <= rd_start_addr;
		else if (addr_accept)
			addr_gen <= addr_gen + 1'b1;	// next burst
	end

	// burst address on the app port, low bits select the beat and stay zero
	assign rd_app_addr = {addr_gen, {(`APP_ADDR_W - `RD_ADDR_W){1'b0}}};

	// address counter, stops issuing at zero
	always_ff @(posedge clk) begin
		if (reset)
			addr_cntr <= '0;
		else if (start_pulse)
			addr_cntr <= rd_burst_cnt;
		else if (addr_accept)
			addr_cntr <= addr_cntr - 1'b1;	// rd_app_en is low at zero
	end
	assign addr_cntr_zero = (addr_cntr == '0);

	// burst counter, counts returned beats down to zero
	always_ff @(posedge clk) begin
		if (reset)
			burst_cntr <= '0;
		else if (start_pulse)
			burst_cntr <= rd_burst_cnt;
		else if (app_rd_data_valid && !burst_cntr_zero)
			burst_cntr <= burst_cntr - 1'b1;
	end
	assign burst_cntr_zero = (burst_cntr == '0);
	assign burst_cntr_one  = (burst_cntr == burst_cnt_t'(1));

	// state register, dropping the request forces idle
	always_ff @(posedge clk) begin
		if (reset || !en_sync2)
			state <= rd_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			rd_idle: if (en_sync3) state_next = rd_read;	// counters load on the same edge
			rd_read: if (burst_cntr_zero) state_next = rd_done;	// zero count goes straight here
			rd_done: state_next = rd_done;	// wait for enable_reading to drop
			default: state_next = rd_idle;
		endcase
	end

	// read request gating
	// acquisition has priority on the memory, and the FIFO needs room for reads in flight
	assign rd_app_en = (state == rd_read) && !acq_enabled && !addr_cntr_zero
		&& !fifo.almost_full;

	// returned beats go straight into the FIFO
	assign fifo.wr_en   = (state == rd_read) && app_rd_data_valid;
	assign fifo.wr_data = app_rd_data;
	assign fifo.wr_last = burst_cntr_one;	// beat arriving with one left closes the fill

	assign reading_done = (state == rd_done);

endmodule

`default_nettype wire

// ==== verilog/rd_path_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_defs.svh"

// write side of the read FIFO, controller to buffer
interface rd_fifo_wr_if import ddr3_rd_pkg::*; ();
	logic  wr_en;	// one beat per cycle while high
	beat_t wr_data;
	logic  wr_last;	// beat closes the fill
	logic  almost_full;	// registered, stops new read requests

	modport producer (
		output wr_en, wr_data, wr_last,
		input  almost_full
	);

	modport fifo (
		input  wr_en, wr_data, wr_last,
		output almost_full
	);
endinterface

// read side of the read FIFO, buffer to unpacker
interface rd_fifo_rd_if import ddr3_rd_pkg::*; ();
	logic  empty;
	beat_t rd_data;	// head entry, valid while empty is low
	logic  rd_last;
	logic  rd_en;	// one-cycle pop strobe

	modport fifo (
		output empty, rd_data, rd_last,
		input  rd_en
	);

	modport consumer (
		input  empty, rd_data, rd_last,
		output rd_en
	);
endinterface

`default_nettype wire

// ==== verilog/ddr3_rd_pkg.sv ====
`default_nettype none

`include "ddr3_rd_defs.svh"

package ddr3_rd_pkg;

	typedef logic [`RD_ADDR_W-1:0]  burst_addr_t;	// 128-bit burst address
	typedef logic [`RD_CNT_W-1:0]   burst_cnt_t;	// bursts per fill
	typedef logic [`APP_ADDR_W-1:0] app_addr_t;	// address on the app port

	typedef logic [`BEAT_W-1:0] beat_t;	// one memory beat
	typedef logic [`WORD_W-1:0] word_t;	// one output word

	// word index inside a beat, 0 is the least significant word
	typedef logic [1:0] word_sel_t;

	// read controller states
	typedef enum logic [1:0] {
		rd_idle,	// waiting for the start request
		rd_read,	// issuing addresses and collecting beats
		rd_done	// all beats in, hold until enable drops
	} rd_state_t;

endpackage

`default_nettype wire

// ==== verilog/ddr3_rd_defs.svh ====
`ifndef DDR3_RD_DEFS_SVH
`define DDR3_RD_DEFS_SVH

// burst address into the DDR3 array, one unit per 128-bit burst
`define RD_ADDR_W 23

// number of bursts in one fill
`define RD_CNT_W 24

// app port address, burst address with three low zero bits
`define APP_ADDR_W 26

// one beat from the memory controller
`define BEAT_W 128

// one word on the output side, four per beat
`define WORD_W 32

// default read FIFO depth in beats
`define RD_FIFO_DEPTH 16

// almost_full when free entries <= margin
// must stay above the number of reads the controller can have in flight
`define RD_FIFO_AFULL_MARGIN 6

`endif
